//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --assert -j 0 --top-module tb_axil_umi -f vlog.f -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- source/axil2umi.sv
// AXI4-Lite slave to UMI host bridge, one transaction at a time
// Writes are right-aligned to the lowest enabled byte before issue
`timescale 1ns/1ps
`default_nettype none

`include "umi_consts.svh"

module axil2umi
    import axil_pkg::*, umi_pkg::*;
(
    input  logic               clk,
    input  logic               nreset,
    input  logic [`UMI_IDW-1:0] chipid,
    input  logic [15:0]        local_routing,
    // AXI4-Lite
    input  axil_aw_t           aw,
    input  logic               awvalid,
    output logic               awready,
    input  axil_w_t            w,
    input  logic               wvalid,
    output logic               wready,
    output axil_resp_t         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  axil_aw_t           ar,
    input  logic               arvalid,
    output logic               arready,
    output axil_r_t            r,
    output logic               rvalid,
    input  logic               rready,
    // UMI host port
    output umi_packet_t        req,
    output logic               req_valid,
    input  logic               req_ready,
    input  umi_packet_t        resp,
    input  logic               resp_valid,
    output logic               resp_ready
);

    logic [1:0]  reset_sync;
    logic        reset_done;
    logic        write_in_flight;
    logic        read_in_flight;
    logic        aw_held;
    logic        w_held;
    logic        ar_held;
    axil_addr_t  addr_q;
    axil_prot_t  prot_q;
    axil_data_t  data_q;
    logic [3:0]  count_q;
    logic [2:0]  offset_q;
    axil_data_t  aligned_data;
    logic [2:0]  byte_offset;
    logic [3:0]  byte_count;
    umi_addr_t   own_srcaddr;
    logic        req_fire;

    // Reset release sync, readies open two cycles after nreset rises
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            reset_sync <= 2'b00;
        end else begin
            reset_sync <= {reset_sync[0], 1'b1};
        end
    end
    assign reset_done = reset_sync[1];

    axil_strobe_align strobe_align_i (
        .strb         (w.strb),
        .data         (w.data),
        .aligned_data (aligned_data),
        .byte_offset  (byte_offset),
        .byte_count   (byte_count)
    );

    // Writes win when both address channels are valid together
    assign awready = !(write_in_flight || read_in_flight) && reset_done;
    assign arready = !(write_in_flight || read_in_flight) && reset_done && !awvalid;
    assign wready  = aw_held && !w_held && reset_done;

    assign req_fire = req_valid && req_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            write_in_flight <= 1'b0;
            read_in_flight  <= 1'b0;
            aw_held         <= 1'b0;
            w_held          <= 1'b0;
            ar_held         <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                write_in_flight <= 1'b1;
                aw_held         <= 1'b1;
            end else if (bvalid && bready) begin
                write_in_flight <= 1'b0;
            end
            if (arvalid && arready) begin
                read_in_flight <= 1'b1;
                ar_held        <= 1'b1;
            end else if (rvalid && rready) begin
                read_in_flight <= 1'b0;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            // Request accepted, beats no longer pending
            if (req_fire) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                ar_held <= 1'b0;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q <= aw.addr;
            prot_q <= aw.prot;
        end else if (arvalid && arready) begin
            addr_q <= ar.addr;
            prot_q <= ar.prot;
        end
        if (wvalid && wready) begin
            data_q   <= aligned_data;
            count_q  <= byte_count;
            offset_q <= byte_offset;
        end
    end

    assign own_srcaddr = {{(`UMI_AW - `UMI_IDW - 40){1'b0}}, chipid, local_routing, 24'h0};

    assign req_valid = ((aw_held && w_held) || ar_held) && reset_done;

    always_comb begin
        req            = '0;
        req.cmd.opcode = write_in_flight ? `UMI_REQ_WRITE : `UMI_REQ_READ;
        req.cmd.len    = write_in_flight ? ({4'h0, count_q} - 8'd1) : 8'(`UMI_DW / 8 - 1);
        req.cmd.prot   = prot_q[1:0];
        req.cmd.eom    = 1'b1;
        req.dstaddr    = write_in_flight ? (addr_q + {61'h0, offset_q}) : addr_q;
        req.srcaddr    = own_srcaddr;
        req.data       = data_q;
    end

    // Response steering, err sits in qos[1:0]
    assign bvalid = write_in_flight && resp_valid && reset_done
                    && (resp.cmd.opcode == `UMI_RESP_WRITE);
    assign rvalid = read_in_flight && resp_valid && reset_done
                    && (resp.cmd.opcode == `UMI_RESP_READ);
    assign bresp  = resp.cmd.qos[1:0];
    assign r.data = resp.data;
    assign r.resp = resp.cmd.qos[1:0];
    assign resp_ready = ((write_in_flight && bready) || (read_in_flight && rready))
                        && reset_done;

    a_req_stable: assert property (@(posedge clk) disable iff (!nreset)
        req_valid && !req_ready |=> req_valid && $stable(req));

    a_one_in_flight: assert property (@(posedge clk) disable iff (!nreset)
        !(write_in_flight && read_in_flight));

    a_resp_route: assert property (@(posedge clk) disable iff (!nreset)
        resp_valid |-> resp.dstaddr == own_srcaddr);

    // Strobe must be one nonzero run of bytes
    a_strb_contig: assert property (@(posedge clk) disable iff (!nreset)
        wvalid && wready |-> byte_count != 4'd0
        && w.strb == axil_strb_t'(((9'd1 << byte_count) - 9'd1) << byte_offset));

endmodule

`default_nettype wire

//--- source/axil_pkg.sv
// AXI4-Lite channel types shared by the bridge and the top level
`default_nettype none

`include "umi_consts.svh"

package axil_pkg;

    typedef logic [`UMI_AW-1:0]   axil_addr_t;
    typedef logic [`UMI_DW-1:0]   axil_data_t;
    typedef logic [`UMI_DW/8-1:0] axil_strb_t;
    typedef logic [2:0]           axil_prot_t;
    typedef logic [1:0]           axil_resp_t;

    // Address channel, used for both AW and AR
    typedef struct packed {
        axil_addr_t addr;
        axil_prot_t prot;
    } axil_aw_t;

    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

endpackage

`default_nettype wire

//--- source/axil_strobe_align.sv
// Write strobe decode for the bridge
// Counts enabled bytes, finds the lowest one and right-aligns the data
`timescale 1ns/1ps
`default_nettype none

module axil_strobe_align
    import axil_pkg::*;
(
    input  axil_strb_t strb,
    input  axil_data_t data,
    output axil_data_t aligned_data,
    output logic [2:0] byte_offset,
    output logic [3:0] byte_count
);

    localparam int NBYTES = $bits(axil_strb_t);

    logic found;

    always_comb begin
        byte_count  = 4'd0;
        byte_offset = 3'd0;
        found       = 1'b0;
        for (int i = 0; i < NBYTES; i++) begin
            byte_count = byte_count + {3'b000, strb[i]};
            // First set bit marks the lowest enabled byte
            if (strb[i] && !found) begin
                byte_offset = i[2:0];
                found       = 1'b1;
            end
        end
    end

    // Shift down by whole bytes
    assign aligned_data = data >> {byte_offset, 3'b000};

endmodule

`default_nettype wire

//--- source/axil_umi_top.sv
// AXI4-Lite bridge with its UMI memory endpoint behind it
`timescale 1ns/1ps
`default_nettype none

`include "umi_consts.svh"

module axil_umi_top
    import axil_pkg::*, umi_pkg::*;
(
    input  logic                clk,
    input  logic                nreset,
    input  logic [`UMI_IDW-1:0] chipid,
    input  logic [15:0]         local_routing,
    input  axil_aw_t            aw,
    input  logic                awvalid,
    output logic                awready,
    input  axil_w_t             w,
    input  logic                wvalid,
    output logic                wready,
    output axil_resp_t          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  axil_aw_t            ar,
    input  logic                arvalid,
    output logic                arready,
    output axil_r_t             r,
    output logic                rvalid,
    input  logic                rready
);

    umi_packet_t req;
    logic        req_valid;
    logic        req_ready;
    umi_packet_t resp;
    logic        resp_valid;
    logic        resp_ready;

    axil2umi bridge_i (
        .clk           (clk),
        .nreset        (nreset),
        .chipid        (chipid),
        .local_routing (local_routing),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready)
    );

    umi_mem_target mem_i (
        .clk        (clk),
        .nreset     (nreset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

//--- source/umi_consts.svh
// Shared widths, opcodes, response codes and endpoint depth
// Included by the packages, the RTL and the testbench
`ifndef UMI_CONSTS_SVH
`define UMI_CONSTS_SVH

// Bus widths
`define UMI_AW  64
`define UMI_DW  64
`define UMI_CW  32
`define UMI_IDW 16

// UMI opcodes
`define UMI_REQ_READ   5'h01
`define UMI_REQ_WRITE  5'h03
`define UMI_RESP_READ  5'h02
`define UMI_RESP_WRITE 5'h04

// AXI response codes
`define AXIL_RESP_OKAY   2'b00
`define AXIL_RESP_SLVERR 2'b10

// Endpoint depth in 64-bit words
`define UMI_MEM_WORDS 64

`endif

//--- source/umi_mem_target.sv
// UMI endpoint backed by a byte memory of UMI_MEM_WORDS words
// One request at a time, response one cycle after acceptance
`timescale 1ns/1ps
`default_nettype none

`include "umi_consts.svh"

module umi_mem_target
    import umi_pkg::*;
(
    input  logic        clk,
    input  logic        nreset,
    input  umi_packet_t req,
    input  logic        req_valid,
    output logic        req_ready,
    output umi_packet_t resp,
    output logic        resp_valid,
    input  logic        resp_ready
);

    localparam int MEM_BYTES = `UMI_MEM_WORDS * 8;
    localparam int BYTE_AW   = $clog2(MEM_BYTES);

    umi_tgt_state_t     state;
    logic [7:0]         mem [MEM_BYTES];
    logic               is_write;
    logic               in_range;
    logic [BYTE_AW-1:0] byte_addr;
    logic [BYTE_AW-1:0] word_base;
    umi_data_t          rd_word;
    logic               accept;

    assign req_ready = (state == TGT_IDLE);
    assign accept    = req_valid && req_ready;
    assign is_write  = (req.cmd.opcode == `UMI_REQ_WRITE);
    assign in_range  = (req.dstaddr[`UMI_AW-1:3] < `UMI_MEM_WORDS);
    assign byte_addr = req.dstaddr[BYTE_AW-1:0];
    assign word_base = {req.dstaddr[BYTE_AW-1:3], 3'b000};

    // Whole word holding dstaddr
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rd_word[8*i +: 8] = mem[word_base + BYTE_AW'(i)];
        end
    end

    // len+1 bytes from dstaddr
    always_ff @(posedge clk) begin
        if (accept && is_write && in_range) begin
            for (int i = 0; i < 8; i++) begin
                if (i <= int'(req.cmd.len)) begin
                    mem[byte_addr + BYTE_AW'(i)] <= req.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= TGT_IDLE;
        end else begin
            case (state)
                TGT_IDLE: if (accept) state <= TGT_RESP;
                TGT_RESP: if (resp_ready) state <= TGT_IDLE;
                default:  state <= TGT_IDLE;
            endcase
        end
    end

    // Response payload, built at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            resp            <= '0;
            resp.cmd.opcode <= is_write ? `UMI_RESP_WRITE : `UMI_RESP_READ;
            resp.cmd.len    <= req.cmd.len;
            resp.cmd.size   <= req.cmd.size;
            resp.cmd.eom    <= 1'b1;
            resp.cmd.qos    <= {2'b00, in_range ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR};
            resp.dstaddr    <= req.srcaddr;
            resp.srcaddr    <= req.dstaddr;
            resp.data       <= (!is_write && in_range) ? rd_word : '0;
        end
    end

    assign resp_valid = (state == TGT_RESP);

    a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

//--- source/umi_pkg.sv
// UMI packet types and the endpoint state encoding
// Command field order follows the UMI bit layout, opcode in the low bits
`default_nettype none

`include "umi_consts.svh"

package umi_pkg;

    typedef logic [`UMI_AW-1:0] umi_addr_t;
    typedef logic [`UMI_DW-1:0] umi_data_t;
    typedef logic [7:0]         umi_len_t;
    typedef logic [4:0]         umi_opcode_t;

    // 32-bit command word, eof is bit 31
    // Responses carry err in qos[1:0]
    typedef struct packed {
        logic        eof;
        logic        eom;
        logic [1:0]  prot;
        logic [3:0]  qos;
        logic [7:0]  atype;
        umi_len_t    len;
        logic [2:0]  size;
        umi_opcode_t opcode;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t  cmd;
        umi_addr_t dstaddr;
        umi_addr_t srcaddr;
        umi_data_t data;
    } umi_packet_t;

    // Endpoint FSM
    typedef enum logic [0:0] {
        TGT_IDLE = 1'b0,
        TGT_RESP = 1'b1
    } umi_tgt_state_t;

endpackage

`default_nettype wire

//--- verification/tb_axil_umi.sv
// Random AXI4-Lite traffic through the bridge into the UMI memory endpoint
// Every B and R beat is compared with a byte model of the endpoint memory
`timescale 1ns/1ps
`default_nettype none

`include "umi_consts.svh"

module tb_axil_umi
    import axil_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int SETTLE       = CLK_PERIOD / 4;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = `UMI_MEM_WORDS;
    localparam int N_RANDOM     = 400;
    // Full-word fill and readback, partial pairs, out-of-range triples, random mix
    localparam int N_OPS        = 2 * MEM_WORDS + 2 * 32 + 3 * 8 + N_RANDOM;
    localparam int CH_AW        = 0;
    localparam int CH_W         = 1;
    localparam int CH_AR        = 2;

    logic        clk;
    logic        nreset;
    logic [15:0] chipid;
    logic [15:0] local_routing;
    axil_aw_t    aw;
    logic        awvalid;
    logic        awready;
    axil_w_t     w;
    logic        wvalid;
    logic        wready;
    axil_resp_t  bresp;
    logic        bvalid;
    logic        bready;
    axil_aw_t    ar;
    logic        arvalid;
    logic        arready;
    axil_r_t     r;
    logic        rvalid;
    logic        rready;
    logic [7:0]  model_mem [MEM_WORDS * 8];
    int          seed;

    axil_umi_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget of 50 cycles per operation on top of reset
    initial begin
        #((N_OPS * 50 + RESET_CYCLES + 8) * CLK_PERIOD);
        $display("Watchdog expired before all operations completed");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t expected,
                              input axil_resp_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_data(input string name, input axil_data_t expected,
                              input axil_data_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_idle();
        check_bit("awready", 1'b0, awready);
        check_bit("wready", 1'b0, wready);
        check_bit("arready", 1'b0, arready);
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("rvalid", 1'b0, rvalid);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic axil_data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    // One contiguous run of 1 to 8 bytes
    function automatic axil_strb_t rand_strobe();
        int count;
        int offset;
        count  = 1 + rand_below(8);
        offset = rand_below(9 - count);
        return axil_strb_t'(((1 << count) - 1) << offset);
    endfunction

    function automatic axil_addr_t rand_addr(input bit allow_oor);
        // Roughly one in eight lands beyond the endpoint
        if (allow_oor && rand_below(8) == 0) begin
            return axil_addr_t'(MEM_WORDS + rand_below(4096)) << 3;
        end
        return axil_addr_t'(rand_below(MEM_WORDS)) << 3;
    endfunction

    function automatic bit in_range(input axil_addr_t addr);
        return addr[63:3] < 61'(MEM_WORDS);
    endfunction

    // Out-of-range reads return zero
    function automatic axil_data_t model_word(input axil_addr_t addr);
        axil_data_t word;
        word = '0;
        if (in_range(addr)) begin
            for (int i = 0; i < 8; i++) begin
                word[8*i +: 8] = model_mem[{addr[8:3], 3'(i)}];
            end
        end
        return word;
    endfunction

    // Enabled bytes land at their own lanes of the addressed word
    function automatic void model_write(input axil_addr_t addr, input axil_data_t data,
                                        input axil_strb_t strb);
        if (in_range(addr)) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) begin
                    model_mem[{addr[8:3], 3'(i)}] = data[8*i +: 8];
                end
            end
        end
    endfunction

    // Called on a falling edge with valid already high, returns on the
    // falling edge after the transfer
    task automatic wait_accept(input int ch);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            #(SETTLE);
            seen = (ch == CH_AW) ? awready : (ch == CH_W) ? wready : arready;
            @(negedge clk);
        end
    endtask

    task automatic wait_response(input bit is_write, input axil_resp_t exp_resp,
                                 input axil_data_t exp_data);
        logic valid_now;
        logic ready_now;
        logic pending;
        logic done;
        pending = 1'b0;
        done    = 1'b0;
        while (!done) begin
            ready_now = ($random(seed) & 3) != 0;
            bready    = is_write && ready_now;
            rready    = !is_write && ready_now;
            #(SETTLE);
            valid_now = is_write ? bvalid : rvalid;
            // No new address or data beat while a transaction is pending
            check_bit("awready", 1'b0, awready);
            check_bit("arready", 1'b0, arready);
            check_bit("wready", 1'b0, wready);
            check_bit(is_write ? "rvalid" : "bvalid", 1'b0, is_write ? rvalid : bvalid);
            if (pending) begin
                check_bit(is_write ? "bvalid" : "rvalid", 1'b1, valid_now);
            end
            if (valid_now) begin
                if (is_write) begin
                    check_resp("bresp", exp_resp, bresp);
                end else begin
                    check_resp("r.resp", exp_resp, r.resp);
                    check_data("r.data", exp_data, r.data);
                end
                done    = ready_now;
                pending = !ready_now;
            end
            @(negedge clk);
        end
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
        axil_resp_t exp_resp;
        exp_resp = in_range(addr) ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
        model_write(addr, data, strb);
        @(negedge clk);
        aw.addr = addr;
        aw.prot = 3'(rand_below(8));
        awvalid = 1'b1;
        w.data  = data;
        w.strb  = strb;
        wvalid  = 1'b1;
        wait_accept(CH_AW);
        awvalid = 1'b0;
        wait_accept(CH_W);
        wvalid = 1'b0;
        wait_response(1'b1, exp_resp, '0);
    endtask

    task automatic do_read(input axil_addr_t addr);
        axil_resp_t exp_resp;
        exp_resp = in_range(addr) ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
        @(negedge clk);
        ar.addr = addr;
        ar.prot = 3'(rand_below(8));
        arvalid = 1'b1;
        wait_accept(CH_AR);
        arvalid = 1'b0;
        wait_response(1'b0, exp_resp, model_word(addr));
    endtask

    initial begin
        axil_addr_t addr;
        seed          = 32'h0bdc_0328;
        nreset        = 1'b0;
        chipid        = 16'h0a5c;
        local_routing = 16'h0001;
        aw            = '0;
        awvalid       = 1'b0;
        w             = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        ar            = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(SETTLE);
            check_idle();
        end
        @(negedge clk);
        nreset = 1'b1;
        // Readies open two cycles after release
        repeat (2) begin
            #(SETTLE);
            check_idle();
            @(negedge clk);
        end
        #(SETTLE);
        check_bit("awready", 1'b1, awready);
        check_bit("arready", 1'b1, arready);
        // Fill every word with full strobes, then read all back
        for (int i = 0; i < MEM_WORDS; i++) begin
            do_write(axil_addr_t'(i) << 3, rand_data(), 8'hff);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            do_read(axil_addr_t'(i) << 3);
        end
        repeat (32) begin
            addr = rand_addr(1'b0);
            do_write(addr, rand_data(), rand_strobe());
            do_read(addr);
        end
        // In-range word with the same low bits must stay untouched
        repeat (8) begin
            addr = axil_addr_t'(MEM_WORDS + rand_below(4096)) << 3;
            do_write(addr, rand_data(), rand_strobe());
            do_read(addr);
            do_read({55'h0, addr[8:0]});
        end
        repeat (N_RANDOM) begin
            addr = rand_addr(1'b1);
            if (rand_below(2) == 0) begin
                do_write(addr, rand_data(), rand_strobe());
            end else begin
                do_read(addr);
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/axil_pkg.sv
source/umi_pkg.sv
source/axil_strobe_align.sv
source/axil2umi.sv
source/umi_mem_target.sv
source/axil_umi_top.sv
verification/tb_axil_umi.sv
